/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal -f sim.f --top-module tb_matrix_display -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -q "All tests passed" &&
echo "PASS" || { echo "FAIL"; exit 1; }

/* sim.f */
+incdir+testbench
src/dz_pkg.sv
src/frame_loader.sv
src/row_scanner.sv
src/dz_panel.sv
src/column_serializer.sv
src/matrix_display_top.sv
testbench/tb_matrix_display.sv

/* src/column_serializer.sv */
module column_serializer import dz_pkg::*; #(
    parameter int N_PANELS = 4
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cols_strobe,
    input  logic [N_PANELS*COLS-1:0]   colg_all,
    input  logic [N_PANELS*COLS-1:0]   colr_all,
    output logic                       sdata,
    output logic                       sclk,
    output logic                       latch
);

    localparam int SH_W  = 2 * COLS * N_PANELS;
    localparam int BIT_W = $clog2(SH_W);

    ser_state_e        state;
    logic [SH_W-1:0]   shreg;
    logic [SH_W-1:0]   load_vec;
    logic [BIT_W-1:0]  bit_cnt;

    // panel 0 at the top, green byte ahead of red
    always_comb
    begin
        for (int p = 0; p < N_PANELS; p++)
        begin
            load_vec[SH_W-1-2*COLS*p -: 2*COLS] =
                {colg_all[p*COLS +: COLS], colr_all[p*COLS +: COLS]};
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state   <= SER_IDLE;
            bit_cnt <= '0;
        end
        else
        begin
            case (state)
                SER_IDLE:
                begin
                    if (cols_strobe)
                    begin
                        state   <= SER_SHIFT;
                        bit_cnt <= '0;
                    end
                end
                SER_SHIFT:
                begin
                    if (bit_cnt == BIT_W'(SH_W - 1))
                        state <= SER_LATCH; // last bit on the line
                    else
                        bit_cnt <= bit_cnt + 1'b1;
                end
                SER_LATCH: state <= SER_IDLE;
                default:   state <= SER_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == SER_IDLE && cols_strobe)
            shreg <= load_vec;
        else if (state == SER_SHIFT)
            shreg <= {shreg[SH_W-2:0], 1'b0}; // msb first
    end

    assign sclk  = (state == SER_SHIFT);
    assign latch = (state == SER_LATCH);
    assign sdata = sclk & shreg[SH_W-1];

    // fires if the row dwell is too short for one full frame
    a_load_when_idle: assert property (@(posedge clk) disable iff (rst)
        cols_strobe |-> (state == SER_IDLE));

endmodule

/* src/dz_panel.sv */
module dz_panel import dz_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  glyph_e           glyph,
    input  logic             warm,
    input  logic [ROW_W-1:0] row_idx,
    input  logic             row_strobe,
    output logic [COLS-1:0]  colg,
    output logic [COLS-1:0]  colr,
    output logic             cols_strobe
);

    logic [COLS-1:0] pattern;

    function automatic logic [COLS-1:0] glyph_row(glyph_e g, logic [ROW_W-1:0] r);
        logic [COLS-1:0] bits;
        bits = '0;
        case (g)
            G_LEVEL0:
            begin
                case (r)
                    3'd2, 3'd5: bits = 8'b0001_1000;
                    3'd3, 3'd4: bits = 8'b0011_1100;
                    default:    bits = '0;
                endcase
            end
            G_LEVEL1:
            begin
                case (r)
                    3'd2, 3'd5: bits = 8'b0011_1000;
                    3'd3, 3'd4: bits = 8'b0111_1100;
                    default:    bits = '0;
                endcase
            end
            G_LEVEL2:
            begin
                case (r)
                    3'd2, 3'd5: bits = 8'b0011_1100;
                    3'd3, 3'd4: bits = 8'b0111_1110;
                    default:    bits = '0;
                endcase
            end
            G_LEVEL3:
            begin
                case (r)
                    3'd1, 3'd6:             bits = 8'b0011_1100;
                    3'd2, 3'd3, 3'd4, 3'd5: bits = 8'b0111_1110;
                    default:                bits = '0;
                endcase
            end
            G_LEVEL4:
            begin
                case (r)
                    3'd0, 3'd7: bits = 8'b0011_1100;
                    3'd1, 3'd6: bits = 8'b0111_1110;
                    default:    bits = 8'b1111_1111; // rows 2..5
                endcase
            end
            G_FULL: bits = 8'b1111_1111;
            G_ICON6:
            begin
                case (r)
                    3'd0: bits = 8'b1100_0011;
                    3'd1: bits = 8'b1110_0011;
                    3'd2: bits = 8'b1111_0001;
                    3'd3: bits = 8'b1110_0011;
                    3'd4: bits = 8'b1100_0111;
                    3'd5: bits = 8'b1110_0111;
                    3'd6: bits = 8'b1111_0111;
                    3'd7: bits = 8'b1111_1011;
                    default: bits = '0;
                endcase
            end
            G_ICON7:
            begin
                case (r)
                    3'd1: bits = 8'b0000_0001;
                    3'd2: bits = 8'b1000_0001;
                    3'd3: bits = 8'b1100_0011;
                    3'd4: bits = 8'b1000_0011;
                    3'd5: bits = 8'b1100_0111;
                    3'd6: bits = 8'b1110_0111;
                    3'd7: bits = 8'b1111_0011;
                    default: bits = '0;
                endcase
            end
            G_ICON8:
            begin
                case (r)
                    3'd1: bits = 8'b0011_1000;
                    3'd2: bits = 8'b0100_0100;
                    3'd3: bits = 8'b0101_1010;
                    3'd4: bits = 8'b0100_1010;
                    3'd5: bits = 8'b0011_0010;
                    3'd6: bits = 8'b1100_0100;
                    3'd7: bits = 8'b0011_1000;
                    default: bits = '0;
                endcase
            end
            G_ICON9:
            begin
                case (r)
                    3'd2: bits = 8'b0110_0000;
                    3'd3: bits = 8'b1111_1100;
                    3'd4: bits = 8'b0011_1111;
                    3'd5: bits = 8'b0011_1110;
                    3'd6: bits = 8'b0001_1100;
                    default: bits = '0;
                endcase
            end
            G_ICON10:
            begin
                case (r)
                    3'd2:       bits = 8'b0001_1000;
                    3'd3:       bits = 8'b0011_1100;
                    3'd4, 3'd5: bits = 8'b0111_1110;
                    3'd6:       bits = 8'b0010_0100;
                    default:    bits = '0;
                endcase
            end
            G_ICON11:
            begin
                case (r)
                    3'd0: bits = 8'b1110_0000;
                    3'd1: bits = 8'b0110_0000;
                    3'd2: bits = 8'b1110_0000;
                    3'd3: bits = 8'b0011_0000;
                    3'd4: bits = 8'b0011_0001;
                    3'd5: bits = 8'b0011_0011;
                    3'd6: bits = 8'b0011_1110;
                    3'd7: bits = 8'b0001_1100;
                    default: bits = '0;
                endcase
            end
            default: bits = '0; // blank and unused codes
        endcase
        return bits;
    endfunction

    assign pattern = glyph_row(glyph, row_idx);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            colg        <= '0;
            colr        <= '0;
            cols_strobe <= 1'b0;
        end
        else
        begin
            cols_strobe <= row_strobe;
            if (row_strobe)
            begin
                colg <= pattern;
                colr <= warm ? pattern : '0; // warm glyphs light red too
            end
        end
    end

endmodule

/* src/dz_pkg.sv */
package dz_pkg;

    parameter int ROWS    = 8;
    parameter int COLS    = 8;
    parameter int GLYPH_W = 4;
    parameter int ROW_W   = $clog2(ROWS);

    // status glyphs, codes 12..14 left unnamed and shown dark
    typedef enum logic [GLYPH_W-1:0] {
        G_LEVEL0 = 4'd0,
        G_LEVEL1 = 4'd1,
        G_LEVEL2 = 4'd2,
        G_LEVEL3 = 4'd3,
        G_LEVEL4 = 4'd4,
        G_FULL   = 4'd5,
        G_ICON6  = 4'd6,
        G_ICON7  = 4'd7,
        G_ICON8  = 4'd8,
        G_ICON9  = 4'd9,
        G_ICON10 = 4'd10,
        G_ICON11 = 4'd11,
        G_BLANK  = 4'd15
    } glyph_e;

    typedef enum logic [1:0] {
        SER_IDLE,
        SER_SHIFT,
        SER_LATCH
    } ser_state_e;

endpackage

/* src/frame_loader.sv */
module frame_loader import dz_pkg::*; #(
    parameter int N_PANELS = 4,
    parameter int PANEL_W  = (N_PANELS > 1) ? $clog2(N_PANELS) : 1
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          en,
    input  logic                          wr,
    input  logic [PANEL_W-1:0]            wr_panel,
    input  glyph_e                        wr_glyph,
    input  logic                          wr_warm,
    output logic [N_PANELS*GLYPH_W-1:0]   glyph,
    output logic [N_PANELS-1:0]           warm
);

    glyph_e     glyph_q [N_PANELS];
    logic [N_PANELS-1:0] warm_q;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < N_PANELS; i++)
            begin
                glyph_q[i] <= G_BLANK;
            end
            warm_q <= '0;
        end
        else
        begin
            for (int i = 0; i < N_PANELS; i++)
            begin
                if (wr && (wr_panel == PANEL_W'(i)))
                begin
                    glyph_q[i] <= wr_glyph;
                    warm_q[i]  <= wr_warm;
                end
            end
        end
    end

    // display off shows blank, stored frame kept
    always_comb
    begin
        for (int i = 0; i < N_PANELS; i++)
        begin
            glyph[i*GLYPH_W +: GLYPH_W] = en ? glyph_q[i] : G_BLANK;
        end
        warm = en ? warm_q : '0;
    end

    a_wr_panel_range: assert property (@(posedge clk) disable iff (rst)
        wr |-> (wr_panel < N_PANELS));

endmodule

/* src/matrix_display_top.sv */
module matrix_display_top import dz_pkg::*; #(
    parameter int N_PANELS  = 4,
    parameter int ROW_DWELL = 96,
    parameter int PANEL_W   = (N_PANELS > 1) ? $clog2(N_PANELS) : 1
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               en,
    input  logic               wr,
    input  logic [PANEL_W-1:0] wr_panel,
    input  glyph_e             wr_glyph,
    input  logic               wr_warm,
    output logic               sdata,
    output logic               sclk,
    output logic               latch,
    output logic [ROWS-1:0]    row
);

    logic [N_PANELS*GLYPH_W-1:0] panel_glyph;
    logic [N_PANELS-1:0]         panel_warm;
    logic [ROW_W-1:0]            row_idx;
    logic                        row_strobe;
    logic [N_PANELS*COLS-1:0]    panel_colg;
    logic [N_PANELS*COLS-1:0]    panel_colr;
    logic [N_PANELS-1:0]         panel_strobe;

    frame_loader #(
        .N_PANELS (N_PANELS),
        .PANEL_W  (PANEL_W)
    ) u_loader (
        .clk      (clk),
        .rst      (rst),
        .en       (en),
        .wr       (wr),
        .wr_panel (wr_panel),
        .wr_glyph (wr_glyph),
        .wr_warm  (wr_warm),
        .glyph    (panel_glyph),
        .warm     (panel_warm)
    );

    row_scanner #(
        .ROW_DWELL (ROW_DWELL)
    ) u_scanner (
        .clk        (clk),
        .rst        (rst),
        .latch      (latch),
        .row_idx    (row_idx),
        .row_strobe (row_strobe),
        .row        (row)
    );

    for (genvar p = 0; p < N_PANELS; p++)
    begin : g_panel
        dz_panel u_panel (
            .clk         (clk),
            .rst         (rst),
            .glyph       (glyph_e'(panel_glyph[p*GLYPH_W +: GLYPH_W])),
            .warm        (panel_warm[p]),
            .row_idx     (row_idx),
            .row_strobe  (row_strobe),
            .colg        (panel_colg[p*COLS +: COLS]),
            .colr        (panel_colr[p*COLS +: COLS]),
            .cols_strobe (panel_strobe[p])
        );
    end

    // all panels run in lockstep, panel 0 stands for the rest
    column_serializer #(
        .N_PANELS (N_PANELS)
    ) u_serializer (
        .clk         (clk),
        .rst         (rst),
        .cols_strobe (panel_strobe[0]),
        .colg_all    (panel_colg),
        .colr_all    (panel_colr),
        .sdata       (sdata),
        .sclk        (sclk),
        .latch       (latch)
    );

endmodule

/* src/row_scanner.sv */
module row_scanner import dz_pkg::*; #(
    parameter int ROW_DWELL = 96
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             latch,
    output logic [ROW_W-1:0] row_idx,
    output logic             row_strobe,
    output logic [ROWS-1:0]  row
);

    localparam int CNT_W = $clog2(ROW_DWELL);

    logic [CNT_W-1:0] dwell_cnt;
    logic [ROW_W-1:0] shown_idx; // row currently on its way out the serial line

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            dwell_cnt  <= '0;
            row_strobe <= 1'b0;
        end
        else
        begin
            row_strobe <= (dwell_cnt == '0);
            if (dwell_cnt == CNT_W'(ROW_DWELL - 1))
                dwell_cnt <= '0;
            else
                dwell_cnt <= dwell_cnt + 1'b1;
        end
    end

    // panels sample the old index on the strobe edge
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row_idx   <= '0;
            shown_idx <= '0;
        end
        else if (row_strobe)
        begin
            shown_idx <= row_idx;
            row_idx   <= row_idx + 1'b1; // wraps after row 7
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            row <= '1; // all rows off
        else if (latch)
            row <= ~(ROWS'(1) << shown_idx);
    end

    a_latch_spacing: assert property (@(posedge clk) disable iff (rst)
        latch |=> (!latch) [*ROW_DWELL-1]);

endmodule

/* testbench/tb_glyph_model.svh */
`ifndef TB_GLYPH_MODEL_SVH
`define TB_GLYPH_MODEL_SVH

// whole glyph as one word, row 0 in the top byte
function automatic logic [63:0] glyph_bitmap(input logic [3:0] code);
    case (code)
        4'd0:    return 64'h0000_183C_3C18_0000;
        4'd1:    return 64'h0000_387C_7C38_0000;
        4'd2:    return 64'h0000_3C7E_7E3C_0000;
        4'd3:    return 64'h003C_7E7E_7E7E_3C00;
        4'd4:    return 64'h3C7E_FFFF_FFFF_7E3C;
        4'd5:    return 64'hFFFF_FFFF_FFFF_FFFF;
        4'd6:    return 64'hC3E3_F1E3_C7E7_F7FB;
        4'd7:    return 64'h0001_81C3_83C7_E7F3;
        4'd8:    return 64'h0038_445A_4A32_C438;
        4'd9:    return 64'h0000_60FC_3F3E_1C00;
        4'd10:   return 64'h0000_183C_7E7E_2400;
        4'd11:   return 64'hE060_E030_3133_3E1C;
        default: return 64'h0; // 12..15 stay dark
    endcase
endfunction

function automatic logic [7:0] glyph_row_ref(input logic [3:0] code, input int r);
    logic [63:0] bm;
    bm = glyph_bitmap(code);
    return bm[63-8*r -: 8];
endfunction

// expected serial word of one row: panel 0 first, green byte before red
function automatic logic [63:0] frame_ref(input logic [15:0] codes, input logic [3:0] warms,
                                          input logic on, input int r);
    logic [63:0] f;
    logic [7:0]  g;
    f = '0;
    for (int p = 0; p < N_PANELS; p++)
    begin
        g = on ? glyph_row_ref(codes[4*p +: 4], r) : 8'h00;
        f[63-16*p -: 16] = {g, (on && warms[p]) ? g : 8'h00};
    end
    return f;
endfunction

// row drive is active low, one line pulled down
function automatic logic [7:0] row_ref(input int r);
    return ~(8'h01 << r);
endfunction

`endif

/* testbench/tb_matrix_display.sv */
module tb_matrix_display import dz_pkg::*; ();

    localparam int N_PANELS   = 4;
    localparam int ROW_DWELL  = 96;
    localparam int FRAME_BITS = 16 * N_PANELS;
    localparam int WAIT_LIMIT = 2000;

    typedef struct packed {
        logic [63:0] frame;
        logic [7:0]  row;
        int          nbits;
        int          gap;
        logic [15:0] glyphs;
        logic [3:0]  warms;
        logic        on;
        logic        fresh;
    } latch_rec_t;

    logic       clk = 1'b0;
    logic       rst;
    logic       en;
    logic       wr;
    logic [1:0] wr_panel;
    glyph_e     wr_glyph;
    logic       wr_warm;
    logic       sdata;
    logic       sclk;
    logic       latch;
    logic [7:0] row;

    logic [15:0] shadow_glyph; // host view of each panel
    logic [3:0]  shadow_warm;
    logic        shadow_en;
    int          gen;          // bumped on every write or en change

    latch_rec_t  recs[$];
    latch_rec_t  pend;
    logic [63:0] shift_acc;
    int          sclk_seen;
    int          cyc;
    int          last_latch;
    int          last_gen;
    logic        row_pending;

    int    frames_done;
    int    checks;
    int    errors;
    int    test_errs;
    string cur_test;
    logic  timed_out;

    `include "tb_glyph_model.svh"

    matrix_display_top #(
        .N_PANELS  (N_PANELS),
        .ROW_DWELL (ROW_DWELL)
    ) DUT (
        .clk      (clk),
        .rst      (rst),
        .en       (en),
        .wr       (wr),
        .wr_panel (wr_panel),
        .wr_glyph (wr_glyph),
        .wr_warm  (wr_warm),
        .sdata    (sdata),
        .sclk     (sclk),
        .latch    (latch),
        .row      (row)
    );

    initial
    begin
        forever #50 clk = ~clk;
    end

    task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        if (exp !== act)
        begin
            errors++;
            $display("[FAIL] %s, %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic write_panel(input int p, input logic [3:0] code, input logic w);
        @(negedge clk);
        wr       = 1'b1;
        wr_panel = 2'(p);
        wr_glyph = glyph_e'(code);
        wr_warm  = w;
        shadow_glyph[4*p +: 4] = code;
        shadow_warm[p]         = w;
        gen++;
        @(negedge clk);
        wr = 1'b0;
    endtask

    task automatic set_enable(input logic v);
        @(negedge clk);
        en        = v;
        shadow_en = v;
        gen++;
    endtask

    // once a wait has timed out the remaining waits fall through
    task automatic wait_frames(input int n);
        int target;
        int waited;
        target = frames_done + n;
        waited = 0;
        while (!timed_out && frames_done < target && waited < WAIT_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        if (!timed_out && frames_done < target)
        begin
            timed_out = 1'b1;
            errors++;
            $display("timeout in %s: latch did not arrive within %0d cycles", cur_test, waited);
        end
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = errors;
    endtask

    task automatic end_test();
        $display("test %-16s %s, %0d mismatches", cur_test,
                 (errors == test_errs) ? "ok" : "wrong", errors - test_errs);
    endtask

    // serial capture, sampled mid-cycle
    always @(negedge clk)
    begin
        if (rst)
        begin
            shift_acc   = '0;
            sclk_seen   = 0;
            cyc         = 0;
            last_latch  = -1;
            last_gen    = gen;
            row_pending = 1'b0;
        end
        else
        begin
            cyc++;
            if (row_pending)
            begin
                pend.row = row; // row settles the cycle after latch
                recs.push_back(pend);
                row_pending = 1'b0;
            end
            if (sclk)
            begin
                shift_acc = {shift_acc[62:0], sdata};
                sclk_seen++;
            end
            if (latch)
            begin
                pend.frame  = shift_acc;
                pend.nbits  = sclk_seen;
                pend.gap    = (last_latch < 0) ? -1 : cyc - last_latch;
                pend.glyphs = shadow_glyph;
                pend.warms  = shadow_warm;
                pend.on     = shadow_en;
                pend.fresh  = (gen == last_gen); // frame may straddle a host change
                last_gen    = gen;
                last_latch  = cyc;
                sclk_seen   = 0;
                row_pending = 1'b1;
            end
        end
    end

    initial
    begin
        latch_rec_t rec;
        int idx;
        idx = 0;
        forever
        begin
            @(negedge clk);
            while (recs.size() > 0)
            begin
                rec = recs.pop_front();
                check_val("row drive", 64'(row_ref(idx)), 64'(rec.row));
                check_val("sclk count", 64'(FRAME_BITS), 64'(rec.nbits));
                if (rec.gap >= 0)
                    check_val("latch spacing", 64'(ROW_DWELL), 64'(rec.gap));
                if (rec.fresh)
                    check_val($sformatf("row %0d columns", idx),
                              frame_ref(rec.glyphs, rec.warms, rec.on, idx), rec.frame);
                idx = (idx + 1) % 8;
                frames_done++;
            end
        end
    end

    initial
    begin
        void'($urandom(32'h62d3e4f2));
        rst          = 1'b1;
        en           = 1'b1;
        wr           = 1'b0;
        wr_panel     = '0;
        wr_glyph     = G_BLANK;
        wr_warm      = 1'b0;
        shadow_glyph = 16'hFFFF;
        shadow_warm  = '0;
        shadow_en    = 1'b1;
        gen          = 0;
        frames_done  = 0;
        checks       = 0;
        errors       = 0;
        timed_out    = 1'b0;

        start_test("reset");
        repeat (16)
        begin
            @(negedge clk);
            check_val("sclk in reset", 64'(0), 64'(sclk));
            check_val("latch in reset", 64'(0), 64'(latch));
            check_val("row in reset", 64'(8'hFF), 64'(row));
        end
        rst = 1'b0;
        wait_frames(8); // blank codes shift out zeros
        end_test();

        start_test("green glyphs");
        for (int k = 0; k < 3; k++)
        begin
            for (int p = 0; p < N_PANELS; p++)
                write_panel(p, 4'(4 * k + p), 1'b0);
            wait_frames(9);
        end
        end_test();

        start_test("random warm");
        for (int k = 0; k < 4; k++)
        begin
            for (int p = 0; p < N_PANELS; p++)
                write_panel(p, 4'($urandom_range(11, 0)), 1'($urandom_range(1, 0)));
            wait_frames(9);
        end
        end_test();

        start_test("unused codes");
        for (int p = 0; p < N_PANELS; p++)
            write_panel(p, 4'(12 + p), 1'b1);
        wait_frames(9);
        end_test();

        start_test("display enable");
        write_panel(0, 4'd5, 1'b1);
        write_panel(1, 4'd8, 1'b0);
        write_panel(2, 4'd11, 1'b1);
        write_panel(3, 4'd2, 1'b0);
        wait_frames(9);
        set_enable(1'b0);
        wait_frames(9);
        set_enable(1'b1);
        wait_frames(9);
        end_test();

        start_test("row scan");
        wait_frames(16);
        end_test();

        $display("%0d checks, %0d mismatches", checks, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule
